// ==== build.f ====
+incdir+src
src/riscv_v_pkg.sv
src/riscv_v_op_pkg.sv
src/riscv_v_bw_and.sv
src/riscv_v_bw_or_xor.sv
src/riscv_v_logic_unit.sv
bench/riscv_v_clk_gen.sv
bench/riscv_v_logic_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f build.f --top-module riscv_v_logic_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vriscv_v_logic_tb > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"

// ==== bench/riscv_v_logic_tb.sv ====
// Directed tests for the vector logic unit
// Inputs are driven on the falling clock edge
// Expected responses come from a byte-level model of the logic and reduction rules
// Bitwise requests keep every srcb byte valid, reductions may mask srcb bytes

`include "riscv_v_cfg.svh"

module riscv_v_logic_tb
    import riscv_v_pkg::*;
    import riscv_v_op_pkg::*;
();

    // About 270 transactions at up to 4 cycles each, plus reset, with margin
    localparam int MAX_CYCLES = 3000;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    riscv_v_logic_req_t req;
    logic               rsp_valid;
    logic               rsp_ready;
    riscv_v_logic_rsp_t rsp;

    integer             seed;
    integer             ready_seed;
    int                 cycle_cnt;
    int                 error_count;
    logic               bp_mode;
    logic               check_latency;
    string              test_name;
    riscv_v_logic_rsp_t exp_q[$];
    int                 acc_cycle_q[$];

    riscv_v_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    riscv_v_logic_unit dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    task automatic abort_run(input string why);
        error_count = error_count + 1;
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [71:0] exp_v,
                               input logic [71:0] act_v);
        if (exp_v !== act_v) begin
            abort_run($sformatf("** Error: %s %s expected %h actual %h",
                                test_name, what, exp_v, act_v));
        end
    endtask

    function automatic riscv_v_byte_t byte_op(input riscv_v_opcode_e op,
                                             input riscv_v_byte_t x, input riscv_v_byte_t y);
        case (op)
            VAND, VREDAND: return x & y;
            VOR, VREDOR:   return x | y;
            default:       return x ^ y;
        endcase
    endfunction

    // Reference model
    function automatic riscv_v_logic_rsp_t model_rsp(input riscv_v_logic_req_t r);
        riscv_v_logic_rsp_t m;
        riscv_v_byte_t      acc;
        riscv_v_byte_t      bb;
        int                 n;
        m = '0;
        n = 1 << r.sew;
        if (r.opcode inside {VAND, VOR, VXOR}) begin
            for (int i = 0; i < `RISCV_V_NUM_BYTES; i++) begin
                if (r.srca.valid[i]) begin
                    m.result[i] = byte_op(r.opcode, r.srca.data[i], r.srcb.data[i]);
                end
            end
            m.valid = r.srca.valid;
        end else begin
            // Byte j of element 0 folded with byte j of every srcb element
            for (int j = 0; j < n; j++) begin
                acc = r.srca.data[j];
                for (int e = 0; e < `RISCV_V_NUM_BYTES / n; e++) begin
                    bb = r.srcb.data[e * n + j];
                    if (!r.srcb.valid[e * n + j]) begin
                        bb = (r.opcode == VREDAND) ? 8'hff : 8'h00;
                    end
                    acc = byte_op(r.opcode, acc, bb);
                end
                m.result[j] = acc;
                m.valid[j]  = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic riscv_v_opcode_e pick_op(input int unsigned n);
        case (n)
            0:       return VAND;
            1:       return VOR;
            2:       return VXOR;
            3:       return VREDAND;
            4:       return VREDOR;
            default: return VREDXOR;
        endcase
    endfunction

    function automatic riscv_v_logic_req_t make_req(input riscv_v_opcode_e op,
                                                   input riscv_v_sew_e sew,
                                                   input logic srcb_full);
        riscv_v_logic_req_t r;
        logic [31:0]        rnd;
        r.opcode      = op;
        r.sew         = sew;
        r.srca.data   = {$random(seed), $random(seed)};
        r.srcb.data   = {$random(seed), $random(seed)};
        rnd           = $random(seed);
        r.srca.valid  = rnd[7:0];
        r.srcb.valid  = srcb_full ? 8'hff : rnd[15:8];
        return r;
    endfunction

    // Holds the request until a rising edge sees req_ready high
    task automatic send_req(input riscv_v_logic_req_t r, output int acc_cycle);
        logic accepted;
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        accepted  = 1'b0;
        acc_cycle = 0;
        while (!accepted) begin
            @(posedge clk);
            accepted  = req_ready;
            acc_cycle = cycle_cnt;
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0);
    endtask

    task automatic test_reset();
        int acc;
        test_name = "reset";
        @(negedge clk);
        check_value("req_ready", 72'(1), 72'(req_ready));
        check_value("rsp_valid", 72'(0), 72'(rsp_valid));
        check_latency = 1'b1;
        send_req(make_req(VAND, SEW8, 1'b1), acc);
        go_idle();
        drain();
        check_latency = 1'b0;
    endtask

    task automatic test_bitwise();
        int          acc;
        logic [31:0] rnd;
        test_name = "bitwise";
        for (int o = 0; o < 3; o++) begin
            repeat (40) begin
                rnd = $random(seed);
                send_req(make_req(pick_op(o), riscv_v_sew_e'(rnd[1:0]), 1'b1), acc);
            end
        end
        go_idle();
        drain();
    endtask

    task automatic test_reduct(input logic srcb_full);
        int acc;
        test_name = srcb_full ? "reduct_full" : "reduct_masked";
        for (int o = 3; o < 6; o++) begin
            for (int s = 0; s < 4; s++) begin
                repeat (srcb_full ? 3 : 2) begin
                    send_req(make_req(pick_op(o), riscv_v_sew_e'(2'(s)), srcb_full), acc);
                end
            end
        end
        go_idle();
        drain();
    endtask

    task automatic test_backpressure();
        int              acc;
        logic [31:0]     rnd;
        riscv_v_opcode_e op;
        test_name = "backpressure";
        bp_mode   = 1'b1;
        repeat (40) begin
            rnd = $random(seed);
            op  = pick_op(rnd % 6);
            send_req(make_req(op, riscv_v_sew_e'(rnd[9:8]), op inside {VAND, VOR, VXOR}), acc);
        end
        go_idle();
        drain();
        bp_mode = 1'b0;
    endtask

    task automatic test_throughput();
        int          acc;
        int          prev;
        logic [31:0] rnd;
        test_name     = "throughput";
        check_latency = 1'b1;
        send_req(make_req(VXOR, SEW32, 1'b1), prev);
        repeat (49) begin
            rnd = $random(seed);
            send_req(make_req(pick_op(rnd % 6), riscv_v_sew_e'(rnd[9:8]), 1'b1), acc);
            check_value("accept cycle", 72'(prev + 1), 72'(acc));
            prev = acc;
        end
        go_idle();
        drain();
        check_latency = 1'b0;
    endtask

    // Counts cycles on the falling edge so it is stable at the rising edge
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    always @(negedge clk) begin
        if (bp_mode) begin
            rsp_ready = 1'($random(ready_seed));
        end else begin
            rsp_ready = 1'b1;
        end
    end

    // Response monitor
    // The queue size equals the number of requests inside the DUT
    always @(posedge clk) begin
        riscv_v_logic_rsp_t exp_rsp;
        int                 lat;
        if (rst_n) begin
            check_value("req_ready", 72'(!(exp_q.size() == 2 && !rsp_ready)), 72'(req_ready));
            if (rsp_valid && exp_q.size() == 0) begin
                abort_run("response valid with no request outstanding");
            end
            if (rsp_valid && rsp_ready) begin
                exp_rsp = exp_q.pop_front();
                lat     = cycle_cnt - acc_cycle_q.pop_front();
                check_value("rsp", exp_rsp, rsp);
                if (check_latency) begin
                    check_value("latency", 72'(2), 72'(lat));
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(model_rsp(req));
                acc_cycle_q.push_back(cycle_cnt);
            end
        end
    end

    initial begin
        req_valid     = 1'b0;
        req           = '0;
        rsp_ready     = 1'b1;
        seed          = 6065;
        ready_seed    = 6065;
        cycle_cnt     = 0;
        error_count   = 0;
        bp_mode       = 1'b0;
        check_latency = 1'b0;
        test_name     = "init";
        wait (rst_n);
        test_reset();
        test_bitwise();
        test_reduct(1'b1);
        test_reduct(1'b0);
        test_backpressure();
        test_throughput();
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : riscv_v_logic_tb

// ==== bench/riscv_v_clk_gen.sv ====
// Testbench clock with a period of 20 time units
// Reset is held low for the first 10 cycles and released on a falling edge

module riscv_v_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : riscv_v_clk_gen

// ==== src/riscv_v_logic_unit.sv ====
// Two-stage vector logic unit with valid/ready on request and response sides
// One request per cycle, at most two in flight, responses in request order
// Bytes outside the result mask are returned as zero

`include "riscv_v_cfg.svh"

module riscv_v_logic_unit
    import riscv_v_pkg::*;
    import riscv_v_op_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  riscv_v_logic_req_t req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output riscv_v_logic_rsp_t rsp
);

    riscv_v_logic_ctrl_t      dec;
    riscv_v_logic_ctrl_t      s1_q;
    logic                     s1_valid;
    logic                     s2_valid;
    logic                     s1_load;
    logic                     s2_load;
    riscv_v_src_byte_vector_t and_res;
    riscv_v_src_byte_vector_t orx_res;
    riscv_v_src_byte_vector_t lane_res;
    riscv_v_logic_rsp_t       rsp_d;

    // Opcode and SEW decode
    always_comb begin
        dec      = '0;
        dec.srca = req.srca;
        dec.srcb = req.srcb;
        case (req.opcode)
            VAND:    dec.is_and = 1'b1;
            VOR:     dec.is_or  = 1'b1;
            VXOR:    dec.is_xor = 1'b1;
            VREDAND: {dec.is_reduct, dec.is_and} = 2'b11;
            VREDOR:  {dec.is_reduct, dec.is_or}  = 2'b11;
            VREDXOR: {dec.is_reduct, dec.is_xor} = 2'b11;
            default: dec.is_reduct = 1'b0;
        endcase

        case (req.sew)
            SEW8:    dec.osize_vector = 4'b0111;
            SEW16:   dec.osize_vector = 4'b0110;
            SEW32:   dec.osize_vector = 4'b0100;
            default: dec.osize_vector = 4'b0000;
        endcase

        // Reductions return only the lowest element
        if (dec.is_reduct) begin
            case (req.sew)
                SEW8:    dec.res_mask = 8'h01;
                SEW16:   dec.res_mask = 8'h03;
                SEW32:   dec.res_mask = 8'h0f;
                default: dec.res_mask = 8'hff;
            endcase
        end else begin
            dec.res_mask = req.srca.valid;
        end
    end

    // Stage advance
    assign s2_load   = ~s2_valid | rsp_ready;
    assign s1_load   = ~s1_valid | s2_load;
    assign req_ready = s1_load;
    assign rsp_valid = s2_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_load) begin
                s1_valid <= req_valid;
            end
            if (s2_load) begin
                s2_valid <= s1_valid;
            end
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (s1_load && req_valid) begin
            s1_q <= dec;
        end
    end

    riscv_v_bw_and u_bw_and (
        .is_reduct    (s1_q.is_reduct),
        .is_and       (s1_q.is_and),
        .osize_vector (s1_q.osize_vector),
        .srca         (s1_q.srca),
        .srcb         (s1_q.srcb),
        .result       (and_res)
    );

    riscv_v_bw_or_xor u_bw_or_xor (
        .is_reduct    (s1_q.is_reduct),
        .is_or        (s1_q.is_or),
        .is_xor       (s1_q.is_xor),
        .osize_vector (s1_q.osize_vector),
        .srca         (s1_q.srca),
        .srcb         (s1_q.srcb),
        .result       (orx_res)
    );

    // Lanes are zero when idle, so an OR merges them
    assign lane_res = and_res | orx_res;

    always_comb begin
        for (int i = 0; i < `RISCV_V_NUM_BYTES; i++) begin
            rsp_d.result[i] = lane_res[i] & {`RISCV_V_BYTE_WIDTH{s1_q.res_mask[i]}};
        end
        rsp_d.valid = s1_q.res_mask;
    end

    // Stage 2 payload
    always_ff @(posedge clk) begin
        if (s2_load && s1_valid) begin
            rsp <= rsp_d;
        end
    end

endmodule : riscv_v_logic_unit

// ==== src/riscv_v_bw_or_xor.sv ====
// Combinational bitwise OR or XOR and the matching reduction
// Output is all zero when neither is_or nor is_xor is set, so it can be OR-merged
// If both selects are high the XOR wins

`include "riscv_v_cfg.svh"

module riscv_v_bw_or_xor
    import riscv_v_pkg::*;
(
    input  logic                     is_reduct,
    input  logic                     is_or,
    input  logic                     is_xor,
    input  osize_vector_t            osize_vector,
    input  riscv_v_alu_data_t        srca,
    input  riscv_v_alu_data_t        srcb,
    output riscv_v_src_byte_vector_t result
);

    localparam int NUM_BLOCKS = `RISCV_V_NUM_BYTES;
    localparam int IDX_BITS   = $clog2(NUM_BLOCKS);

    logic                           op_en;
    riscv_v_src_byte_vector_t       srca_gated;
    riscv_v_src_byte_vector_t       srcb_bw;
    logic [IDX_BITS-1:0]            lane_mask;
    logic [`RISCV_V_OSIZE_BITS-1:0] fold_sel;

    assign op_en = is_or | is_xor;

    for (genvar i = 0; i < NUM_BLOCKS; i++) begin : gen_inputs
        assign srca_gated[i] = srca.data[i] & {`RISCV_V_BYTE_WIDTH{op_en}};
        // Invalid bytes become zero, neutral for both OR and XOR
        assign srcb_bw[i]    = srcb.data[i] &
                               {`RISCV_V_BYTE_WIDTH{srcb.valid[i] & op_en}};
    end

    for (genvar b = 0; b < IDX_BITS; b++) begin : gen_lane_mask
        assign lane_mask[b] = ~(is_reduct & osize_vector[b]);
    end

    // Lowest set osize bit gives the fold distance
    always_comb begin : sel_fold
        logic lower_set;
        lower_set = 1'b0;
        for (int k = 0; k < `RISCV_V_OSIZE_BITS; k++) begin
            fold_sel[k] = osize_vector[k] & ~lower_set;
            lower_set   = lower_set | osize_vector[k];
        end
    end

    // Same fold chain as the AND lane
    // Top element blocks start from element 0 of srca, the rest take the block one element up
    always_comb begin : or_xor_chain
        riscv_v_src_byte_vector_t chain;
        riscv_v_byte_t            a_in;
        logic [IDX_BITS-1:0]      src_idx;
        chain = '0;
        for (int blk = NUM_BLOCKS - 1; blk >= 0; blk--) begin
            src_idx = IDX_BITS'(blk) & lane_mask;
            a_in    = srca_gated[src_idx];
            for (int k = 0; k < `RISCV_V_OSIZE_BITS; k++) begin
                if ((blk + (1 << k) < NUM_BLOCKS) && is_reduct && fold_sel[k]) begin
                    a_in = chain[blk + (1 << k)];
                end
            end
            if (is_xor) begin
                chain[blk] = a_in ^ srcb_bw[blk];
            end else begin
                chain[blk] = a_in | srcb_bw[blk];
            end
        end
        result = chain;
    end

endmodule : riscv_v_bw_or_xor

// ==== src/riscv_v_bw_and.sv ====
// Combinational bitwise AND and AND reduction over the byte blocks
// Output is all zero when is_and is low
// In a reduction only the lowest element of the result is meaningful

`include "riscv_v_cfg.svh"

module riscv_v_bw_and
    import riscv_v_pkg::*;
(
    input  logic                     is_reduct,
    input  logic                     is_and,
    input  osize_vector_t            osize_vector,
    input  riscv_v_alu_data_t        srca,
    input  riscv_v_alu_data_t        srcb,
    output riscv_v_src_byte_vector_t result
);

    localparam int NUM_BLOCKS = `RISCV_V_NUM_BYTES;
    localparam int IDX_BITS   = $clog2(NUM_BLOCKS);

    riscv_v_src_byte_vector_t      srca_gated;
    riscv_v_src_byte_vector_t      srcb_bw;
    logic [IDX_BITS-1:0]           lane_mask;
    logic [`RISCV_V_OSIZE_BITS-1:0] fold_sel;

    for (genvar i = 0; i < NUM_BLOCKS; i++) begin : gen_inputs
        assign srca_gated[i] = srca.data[i] & {`RISCV_V_BYTE_WIDTH{is_and}};
        // Invalid bytes become all ones so they drop out of the AND
        assign srcb_bw[i]    = srcb.data[i] | {`RISCV_V_BYTE_WIDTH{~srcb.valid[i]}};
    end

    // Index mask so the blocks of the top element read element 0 of srca
    for (genvar b = 0; b < IDX_BITS; b++) begin : gen_lane_mask
        assign lane_mask[b] = ~(is_reduct & osize_vector[b]);
    end

    // Fold distance is the element size, which is the lowest set osize bit
    always_comb begin : sel_fold
        logic lower_set;
        lower_set = 1'b0;
        for (int k = 0; k < `RISCV_V_OSIZE_BITS; k++) begin
            fold_sel[k] = osize_vector[k] & ~lower_set;
            lower_set   = lower_set | osize_vector[k];
        end
    end

    // Chain from the top block down
    // In a reduction each block takes the result one element above it,
    // so block 0 ends up with the scalar ANDed with every srcb element
    always_comb begin : and_chain
        riscv_v_src_byte_vector_t chain;
        riscv_v_byte_t            a_in;
        logic [IDX_BITS-1:0]      src_idx;
        chain = '0;
        for (int blk = NUM_BLOCKS - 1; blk >= 0; blk--) begin
            src_idx = IDX_BITS'(blk) & lane_mask;
            a_in    = srca_gated[src_idx];
            for (int k = 0; k < `RISCV_V_OSIZE_BITS; k++) begin
                if ((blk + (1 << k) < NUM_BLOCKS) && is_reduct && fold_sel[k]) begin
                    a_in = chain[blk + (1 << k)];
                end
            end
            chain[blk] = a_in & srcb_bw[blk];
        end
        result = chain;
    end

endmodule : riscv_v_bw_and

// ==== src/riscv_v_op_pkg.sv ====
// Operation types for the vector logic unit
// Only the logic and logic-reduction opcodes exist, other vector ops are not decoded
// Codes outside the opcode enum produce an all-zero result

package riscv_v_op_pkg;

`include "riscv_v_cfg.svh"

    import riscv_v_pkg::*;

    typedef enum logic [2:0] {
        VAND    = 3'd0,
        VOR     = 3'd1,
        VXOR    = 3'd2,
        VREDAND = 3'd3,
        VREDOR  = 3'd4,
        VREDXOR = 3'd5
    } riscv_v_opcode_e;

    // Element width
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } riscv_v_sew_e;

    // Request from the source side
    // For reductions element 0 of srca is the scalar operand
    typedef struct packed {
        riscv_v_opcode_e   opcode;
        riscv_v_sew_e      sew;
        riscv_v_alu_data_t srca;
        riscv_v_alu_data_t srcb;
    } riscv_v_logic_req_t;

    // Response to the sink side
    typedef struct packed {
        riscv_v_src_byte_vector_t      result;
        logic [`RISCV_V_NUM_BYTES-1:0] valid;
    } riscv_v_logic_rsp_t;

    // Decoded request held in the first pipeline stage
    typedef struct packed {
        logic                          is_and;
        logic                          is_or;
        logic                          is_xor;
        logic                          is_reduct;
        osize_vector_t                 osize_vector;
        riscv_v_alu_data_t             srca;
        riscv_v_alu_data_t             srcb;
        logic [`RISCV_V_NUM_BYTES-1:0] res_mask;
    } riscv_v_logic_ctrl_t;

endpackage : riscv_v_op_pkg

// ==== src/riscv_v_pkg.sv ====
// Datapath types shared by the lane blocks and the top level
// Byte 0 of a word is the least significant byte
// Valid masks carry one bit per byte block

package riscv_v_pkg;

`include "riscv_v_cfg.svh"

    // One byte block
    typedef logic [`RISCV_V_BYTE_WIDTH-1:0] riscv_v_byte_t;

    // Full datapath word as an array of bytes
    typedef riscv_v_byte_t [`RISCV_V_NUM_BYTES-1:0] riscv_v_src_byte_vector_t;

    // Operand word with its per-byte valid mask
    typedef struct packed {
        riscv_v_src_byte_vector_t        data;
        logic [`RISCV_V_NUM_BYTES-1:0]   valid;
    } riscv_v_alu_data_t;

    // Reduction fold code
    // Bit k set when a reduction folds across a byte distance of 2**k
    //   SEW8  -> 4'b0111
    //   SEW16 -> 4'b0110
    //   SEW32 -> 4'b0100
    //   SEW64 -> 4'b0000
    // The lowest set bit gives the element size in bytes
    typedef logic [`RISCV_V_OSIZE_BITS-1:0] osize_vector_t;

endpackage : riscv_v_pkg

// ==== src/riscv_v_cfg.svh ====
// Datapath sizing for the vector logic lane
// The datapath is one word of NUM_BYTES byte blocks, with no sequencing across words
// OSIZE_BITS is log2(NUM_BYTES) + 1 and must track NUM_BYTES

`ifndef RISCV_V_CFG_SVH
`define RISCV_V_CFG_SVH

// Number of byte blocks in one datapath word
`define RISCV_V_NUM_BYTES 8

// Width of one byte block
`define RISCV_V_BYTE_WIDTH 8

// Width of the reduction fold code
// One bit per fold distance up to the largest element size
`define RISCV_V_OSIZE_BITS 4

`endif
